// File: verilog/ppuRegMapPkg.sv
`default_nettype none

package ppuRegMapPkg;

	localparam int byteW = 8;
	localparam int vramAddrW = 14;

	// CPU-visible register numbers
	typedef enum logic [2:0] {
		regCtrl    = 3'd0,
		regMask    = 3'd1,
		regStatus  = 3'd2,
		regOamAddr = 3'd3,
		regOamData = 3'd4,
		regScroll  = 3'd5,
		regAddr    = 3'd6,
		regData    = 3'd7
	} regNumE;

	// one decoded access, alive for a single cycle
	typedef enum logic [3:0] {
		opNone,
		opWrCtrl,
		opWrMask,
		opRdStatus,
		opWrScroll,
		opWrAddr,
		opRdData,
		opWrData,
		opIgnore
	} regOpE;

endpackage

`default_nettype wire

// File: verilog/ppuFieldsPkg.sv
`default_nettype none

package ppuFieldsPkg;

	// register 0
	typedef struct packed {
		logic       nmiEnable;
		logic       slave;
		logic       tallSprites;
		logic       bgTable;
		logic       objTable;
		logic       inc32;
		logic [1:0] nameTable;
	} ctrlFieldsT;

	// register 1
	typedef struct packed {
		logic empBlue;
		logic empGreen;
		logic empRed;
		logic objEnable;
		logic bgEnable;
		logic objShowLeft;
		logic bgShowLeft;
		logic grey;
	} maskFieldsT;

	// data port address steps, across or down a name table
	localparam int incSmall = 1;
	localparam int incLarge = 32;

	localparam int clipCols = 8;

endpackage

`default_nettype wire

// File: verilog/regBusIf.sv
`timescale 1ns/1ps
`default_nettype none

interface regBusIf;
	import ppuRegMapPkg::*;

	// op and wdata come from the decoder one cycle after acceptance
	regOpE op;
	logic [byteW-1:0] wdata;

	// read sources, sampled by the decoder while op is live
	logic [byteW-1:0] statusData;
	logic [byteW-1:0] dataRdata;

	modport decoder (
		output op,
		output wdata,
		input  statusData,
		input  dataRdata
	);

	modport regs (
		input  op,
		input  wdata,
		output statusData,
		output dataRdata
	);

endinterface

`default_nettype wire

// File: verilog/cpuBusDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module cpuBusDecoder (
	input  logic                            pclk,
	input  logic                            arstN,
	input  logic                            reqValid,
	output logic                            reqReady,
	input  logic [2:0]                      reqReg,
	input  logic                            reqRnW,
	input  logic [ppuRegMapPkg::byteW-1:0]  reqWdata,
	output logic                            rspValid,
	input  logic                            rspReady,
	output logic [ppuRegMapPkg::byteW-1:0]  rspRdata,
	regBusIf.decoder                        bus
);
	import ppuRegMapPkg::*;

	regNumE regSel;
	regOpE nextOp;
	logic accept;
	logic pendRead;
	logic [byteW-1:0] readMux;

	// a read in flight counts as pending until its response is taken
	assign reqReady = !(pendRead || (rspValid && !rspReady));
	assign accept = reqValid && reqReady;
	assign regSel = regNumE'(reqReg);

	always_comb begin
		nextOp = opIgnore;
		case (regSel)
			regCtrl:   if (!reqRnW) nextOp = opWrCtrl;
			regMask:   if (!reqRnW) nextOp = opWrMask;
			regStatus: if (reqRnW) nextOp = opRdStatus;
			regScroll: if (!reqRnW) nextOp = opWrScroll;
			regAddr:   if (!reqRnW) nextOp = opWrAddr;
			regData:   nextOp = reqRnW ? opRdData : opWrData;
			default:   nextOp = opIgnore;
		endcase
	end

	always_comb begin
		case (bus.op)
			opRdStatus: readMux = bus.statusData;
			opRdData:   readMux = bus.dataRdata;
			default:    readMux = '0;
		endcase
	end

	always_ff @(posedge pclk or negedge arstN) begin
		if (!arstN) begin
			bus.op <= opNone;
			pendRead <= 1'b0;
			rspValid <= 1'b0;
		end else begin
			bus.op <= accept ? nextOp : opNone;
			pendRead <= accept && reqRnW;
			if (pendRead)
				rspValid <= 1'b1;
			else if (rspReady)
				rspValid <= 1'b0;
		end
	end

	always_ff @(posedge pclk) begin
		if (accept)
			bus.wdata <= reqWdata;
		if (pendRead)
			rspRdata <= readMux;
	end

endmodule

`default_nettype wire

// File: verilog/ctrlRegs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlRegs (
	input  logic                     pclk,
	input  logic                     arstN,
	regBusIf.regs                    bus,
	input  logic                     vblStart,
	output ppuFieldsPkg::ctrlFieldsT ctrl,
	output ppuFieldsPkg::maskFieldsT mask,
	output logic                     nmi
);
	import ppuRegMapPkg::*;

	logic vblFlag;

	// only bit 7 is modelled, overflow and sprite 0 hit read as zero
	assign bus.statusData = {vblFlag, {(byteW-1){1'b0}}};

	assign nmi = vblFlag && ctrl.nmiEnable;

	always_ff @(posedge pclk or negedge arstN) begin
		if (!arstN) begin
			ctrl <= '0;
			mask <= '0;
		end else begin
			case (bus.op)
				opWrCtrl: ctrl <= bus.wdata;
				opWrMask: mask <= bus.wdata;
				default: ;
			endcase
		end
	end

	// a new vblank beats a status read in the same cycle
	always_ff @(posedge pclk or negedge arstN) begin
		if (!arstN)
			vblFlag <= 1'b0;
		else if (vblStart)
			vblFlag <= 1'b1;
		else if (bus.op == opRdStatus)
			vblFlag <= 1'b0;
	end

endmodule

`default_nettype wire

// File: verilog/scrollAddrRegs.sv
`timescale 1ns/1ps
`default_nettype none

module scrollAddrRegs (
	input  logic                               pclk,
	input  logic                               arstN,
	regBusIf.regs                              bus,
	input  logic                               inc32,
	input  logic [ppuRegMapPkg::byteW-1:0]     vramRdata,
	output logic                               vramStrobe,
	output logic                               vramWe,
	output logic [ppuRegMapPkg::vramAddrW-1:0] vramAddr,
	output logic [ppuRegMapPkg::byteW-1:0]     vramWdata,
	output logic [ppuRegMapPkg::byteW-1:0]     scrollX,
	output logic [ppuRegMapPkg::byteW-1:0]     scrollY
);
	import ppuRegMapPkg::*;
	import ppuFieldsPkg::*;

	logic toggle;
	logic [vramAddrW-1:0] addrReg;
	logic [vramAddrW-1:0] step;
	logic [byteW-1:0] rdSample;
	logic dataOp;

	assign step = inc32 ? vramAddrW'(incLarge) : vramAddrW'(incSmall);
	assign dataOp = (bus.op == opRdData) || (bus.op == opWrData);

	// vramRdata as it was on the edge that accepted the read
	always_ff @(posedge pclk)
		rdSample <= vramRdata;

	assign bus.dataRdata = rdSample;

	// shared by registers 5 and 6
	always_ff @(posedge pclk or negedge arstN) begin
		if (!arstN)
			toggle <= 1'b0;
		else if (bus.op == opRdStatus)
			toggle <= 1'b0;
		else if (bus.op == opWrScroll || bus.op == opWrAddr)
			toggle <= !toggle;
	end

	always_ff @(posedge pclk or negedge arstN) begin
		if (!arstN) begin
			scrollX <= '0;
			scrollY <= '0;
			addrReg <= '0;
		end else begin
			case (bus.op)
				opWrScroll: begin
					if (!toggle)
						scrollX <= bus.wdata;
					else
						scrollY <= bus.wdata;
				end
				// high byte first, only six bits of it fit
				opWrAddr: begin
					if (!toggle)
						addrReg[vramAddrW-1:byteW] <= bus.wdata[vramAddrW-byteW-1:0];
					else
						addrReg[byteW-1:0] <= bus.wdata;
				end
				opRdData, opWrData: addrReg <= addrReg + step;
				default: ;
			endcase
		end
	end

	// memory port sees the address from before the increment
	always_ff @(posedge pclk or negedge arstN) begin
		if (!arstN) begin
			vramStrobe <= 1'b0;
			vramWe <= 1'b0;
			vramAddr <= '0;
			vramWdata <= '0;
		end else begin
			vramStrobe <= dataOp;
			vramWe <= bus.op == opWrData;
			if (dataOp) begin
				vramAddr <= addrReg;
				vramWdata <= bus.wdata;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/clipper.sv
`timescale 1ns/1ps
`default_nettype none

module clipper (
	input  logic [8:0]               pixelX,
	input  ppuFieldsPkg::maskFieldsT mask,
	output logic                     bgOn,
	output logic                     objOn
);
	import ppuFieldsPkg::*;

	logic leftCol;

	// leftmost eight columns may hide either layer
	assign leftCol = pixelX < 9'(clipCols);

	assign bgOn = mask.bgEnable && (!leftCol || mask.bgShowLeft);
	assign objOn = mask.objEnable && (!leftCol || mask.objShowLeft);

endmodule

`default_nettype wire

// File: verilog/ppuRegs.sv
`timescale 1ns/1ps
`default_nettype none

module ppuRegs (
	input  logic                               pclk,
	input  logic                               arstN,
	input  logic                               reqValid,
	output logic                               reqReady,
	input  logic [2:0]                         reqReg,
	input  logic                               reqRnW,
	input  logic [ppuRegMapPkg::byteW-1:0]     reqWdata,
	output logic                               rspValid,
	input  logic                               rspReady,
	output logic [ppuRegMapPkg::byteW-1:0]     rspRdata,
	input  logic                               vblStart,
	input  logic [8:0]                         pixelX,
	input  logic [ppuRegMapPkg::byteW-1:0]     vramRdata,
	output logic                               vramStrobe,
	output logic                               vramWe,
	output logic [ppuRegMapPkg::vramAddrW-1:0] vramAddr,
	output logic [ppuRegMapPkg::byteW-1:0]     vramWdata,
	output logic [ppuRegMapPkg::byteW-1:0]     scrollX,
	output logic [ppuRegMapPkg::byteW-1:0]     scrollY,
	output logic [ppuRegMapPkg::byteW-1:0]     ctrl,
	output logic [ppuRegMapPkg::byteW-1:0]     mask,
	output logic                               nmi,
	output logic                               bgOn,
	output logic                               objOn
);
	import ppuFieldsPkg::*;

	ctrlFieldsT ctrlF;
	maskFieldsT maskF;

	regBusIf bus ();

	assign ctrl = ctrlF;
	assign mask = maskF;

	cpuBusDecoder decoder0 (
		.pclk(pclk),
		.arstN(arstN),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.reqReg(reqReg),
		.reqRnW(reqRnW),
		.reqWdata(reqWdata),
		.rspValid(rspValid),
		.rspReady(rspReady),
		.rspRdata(rspRdata),
		.bus(bus.decoder)
	);

	ctrlRegs ctrl0 (
		.pclk(pclk),
		.arstN(arstN),
		.bus(bus.regs),
		.vblStart(vblStart),
		.ctrl(ctrlF),
		.mask(maskF),
		.nmi(nmi)
	);

	scrollAddrRegs scroll0 (
		.pclk(pclk),
		.arstN(arstN),
		.bus(bus.regs),
		.inc32(ctrlF.inc32),
		.vramRdata(vramRdata),
		.vramStrobe(vramStrobe),
		.vramWe(vramWe),
		.vramAddr(vramAddr),
		.vramWdata(vramWdata),
		.scrollX(scrollX),
		.scrollY(scrollY)
	);

	clipper clip0 (
		.pixelX(pixelX),
		.mask(maskF),
		.bgOn(bgOn),
		.objOn(objOn)
	);

endmodule

`default_nettype wire

// File: dv/ppuRegs_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ppuRegs_checker (
	input logic                           pclk,
	input logic                           arstN,
	input logic                           reqValid,
	input logic                           reqReady,
	input logic                           reqRnW,
	input logic                           rspValid,
	input logic                           rspReady,
	input logic [ppuRegMapPkg::byteW-1:0] rspRdata,
	input logic                           vramStrobe,
	input logic                           toggle,
	input logic                           statusRead
);

	// a response that is not taken stays valid with the same byte
	rspHeld: assert property (@(posedge pclk) disable iff (!arstN)
		rspValid && !rspReady |=> rspValid && $stable(rspRdata))
		else $error("read response changed before it was taken");

	// stall only behind a read just accepted or a response not yet taken
	reqStall: assert property (@(posedge pclk) disable iff (!arstN)
		!reqReady |-> (rspValid && !rspReady) || $past(reqValid && reqReady && reqRnW))
		else $error("request channel stalled with no response pending");

	strobeSingle: assert property (@(posedge pclk) disable iff (!arstN)
		vramStrobe |=> !vramStrobe)
		else $error("memory strobe high for two cycles");

	toggleCleared: assert property (@(posedge pclk) disable iff (!arstN)
		statusRead |=> !toggle)
		else $error("write toggle still set after a status read");

endmodule

bind cpuBusDecoder ppuRegs_checker busChk0 (
	.pclk(pclk),
	.arstN(arstN),
	.reqValid(reqValid),
	.reqReady(reqReady),
	.reqRnW(reqRnW),
	.rspValid(rspValid),
	.rspReady(rspReady),
	.rspRdata(rspRdata),
	.vramStrobe(1'b0),
	.toggle(1'b0),
	.statusRead(1'b0)
);

// only the strobe and toggle checks are live here
bind scrollAddrRegs ppuRegs_checker scrollChk0 (
	.pclk(pclk),
	.arstN(arstN),
	.reqValid(1'b0),
	.reqReady(1'b1),
	.reqRnW(1'b0),
	.rspValid(1'b0),
	.rspReady(1'b1),
	.rspRdata('0),
	.vramStrobe(vramStrobe),
	.toggle(toggle),
	.statusRead(bus.op == ppuRegMapPkg::opRdStatus)
);

`default_nettype wire

// File: dv/ppuRegs_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ppuRegs_tb;
	import ppuRegMapPkg::*;

	localparam int period = 100;
	localparam int resetCycles = 8;
	localparam int cyclesPerTest = 20;
	localparam int maxTests = 64;

	logic pclk;
	logic arstN;
	logic reqValid;
	logic reqReady;
	logic [2:0] reqReg;
	logic reqRnW;
	logic [byteW-1:0] reqWdata;
	logic rspValid;
	logic rspReady;
	logic [byteW-1:0] rspRdata;
	logic vblStart;
	logic [8:0] pixelX;
	logic [byteW-1:0] vramRdata;
	logic vramStrobe;
	logic vramWe;
	logic [vramAddrW-1:0] vramAddr;
	logic [byteW-1:0] vramWdata;
	logic [byteW-1:0] scrollX;
	logic [byteW-1:0] scrollY;
	logic [byteW-1:0] ctrl;
	logic [byteW-1:0] mask;
	logic nmi;
	logic bgOn;
	logic objOn;

	// one entry per line of the stimulus file
	logic [8*24-1:0] testName [maxTests];
	logic [8*8-1:0] testOp [maxTests];
	logic [2:0] testReg [maxTests];
	logic [31:0] testData [maxTests];
	logic [31:0] testExp [maxTests];
	int testCount;
	int curTest;
	int errCount;
	logic loaded;

	ppuRegs dut0 (
		.pclk(pclk),
		.arstN(arstN),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.reqReg(reqReg),
		.reqRnW(reqRnW),
		.reqWdata(reqWdata),
		.rspValid(rspValid),
		.rspReady(rspReady),
		.rspRdata(rspRdata),
		.vblStart(vblStart),
		.pixelX(pixelX),
		.vramRdata(vramRdata),
		.vramStrobe(vramStrobe),
		.vramWe(vramWe),
		.vramAddr(vramAddr),
		.vramWdata(vramWdata),
		.scrollX(scrollX),
		.scrollY(scrollY),
		.ctrl(ctrl),
		.mask(mask),
		.nmi(nmi),
		.bgOn(bgOn),
		.objOn(objOn)
	);

	always #(period / 2) pclk = ~pclk;

	// returns the number of tests, or -1 when the file is missing
	function automatic int loadTests();
		int fd;
		int n;
		int fields;
		int regN;
		string line;
		logic [8*24-1:0] name;
		logic [8*8-1:0] op;
		logic [31:0] data;
		logic [31:0] expVal;
		n = 0;
		fd = $fopen("dv/ppuRegs_input.txt", "r");
		if (fd == 0)
			return -1;
		while (!$feof(fd) && n < maxTests) begin
			fields = $fgets(line, fd);
			if (fields > 0 && line.getc(0) != "#") begin
				fields = $sscanf(line, "%s %s %d %h %h", name, op, regN, data, expVal);
				if (fields == 5) begin
					testName[n] = name;
					testOp[n] = op;
					testReg[n] = 3'(regN);
					testData[n] = data;
					testExp[n] = expVal;
					n++;
				end
			end
		end
		$fclose(fd);
		return n;
	endfunction

	task automatic sendRequest(input logic [2:0] regN, input logic rnw,
			input logic [7:0] wdata, input logic [7:0] vdata);
		logic taken;
		reqValid = 1'b1;
		reqReg = regN;
		reqRnW = rnw;
		reqWdata = wdata;
		vramRdata = vdata;
		taken = 1'b0;
		while (!taken) begin
			@(negedge pclk);
			taken = reqReady;
			@(posedge pclk);
			#5;
		end
		reqValid = 1'b0;
	endtask

	// rspReady stays low a random number of cycles before the handshake
	task automatic takeResponse(output logic [31:0] got);
		int holdCycles;
		holdCycles = $urandom % 4;
		do
			@(negedge pclk);
		while (!rspValid);
		repeat (holdCycles) @(negedge pclk);
		@(posedge pclk);
		#5;
		rspReady = 1'b1;
		@(negedge pclk);
		got = 32'(rspRdata);
		@(posedge pclk);
		#5;
		rspReady = 1'b0;
	endtask

	// what a write to each register makes visible
	function automatic logic [31:0] observeWrite(input logic [2:0] regN);
		case (regN)
			3'd0: return {24'h0, ctrl};
			3'd1: return {24'h0, mask};
			3'd5: return {16'h0, scrollY, scrollX};
			3'd7: return {6'h0, vramStrobe, vramWe, 2'b00, vramAddr, vramWdata};
			default: return {16'h0, ctrl, mask};
		endcase
	endfunction

	task automatic runTest(input int i);
		logic [31:0] got;
		logic known;
		got = '0;
		known = 1'b1;
		if (testOp[i] == 64'("write")) begin
			sendRequest(testReg[i], 1'b0, testData[i][7:0], 8'h00);
			@(posedge pclk);
			@(negedge pclk);
			got = observeWrite(testReg[i]);
			@(posedge pclk);
			#5;
		end else if (testOp[i] == 64'("read")) begin
			sendRequest(testReg[i], 1'b1, 8'h00, testData[i][7:0]);
			takeResponse(got);
		end else if (testOp[i] == 64'("vblank")) begin
			vblStart = testData[i][0];
			@(posedge pclk);
			#5;
			vblStart = 1'b0;
			@(negedge pclk);
			got = {31'h0, nmi};
			@(posedge pclk);
			#5;
		end else if (testOp[i] == 64'("pixel")) begin
			pixelX = testData[i][8:0];
			@(negedge pclk);
			got = {30'h0, bgOn, objOn};
			@(posedge pclk);
			#5;
		end else begin
			known = 1'b0;
		end
		if (!known) begin
			$display("test %0s has an unknown operation %0s", testName[i], testOp[i]);
			errCount++;
		end else begin
			assert (got == testExp[i])
				$display("passed %0s value %h", testName[i], got);
			else begin
				$display("CHECK FAILED %0s expected %h actual %h", testName[i], testExp[i], got);
				errCount++;
			end
		end
	endtask

	initial begin
		loaded = 1'b0;
		wait (loaded);
		repeat (testCount * cyclesPerTest) @(posedge pclk);
		$display("timeout after %0d cycles, test %0s never finished",
			testCount * cyclesPerTest, testName[curTest]);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		void'($urandom(10813));
		pclk = 1'b0;
		arstN = 1'b0;
		reqValid = 1'b0;
		reqReg = '0;
		reqRnW = 1'b0;
		reqWdata = '0;
		rspReady = 1'b0;
		vblStart = 1'b0;
		pixelX = '0;
		vramRdata = '0;
		errCount = 0;
		curTest = 0;
		testCount = loadTests();
		if (testCount <= 0) begin
			$display("no tests could be read from dv/ppuRegs_input.txt");
			$display(">>> FAIL");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (resetCycles) @(posedge pclk);
			#5;
			arstN = 1'b1;
			for (int i = 0; i < testCount; i++) begin
				curTest = i;
				runTest(i);
			end
			$display("tests %0d passed %0d failed %0d", testCount, testCount - errCount, errCount);
			if (errCount == 0)
				$display(">>> PASS");
			else
				$display(">>> FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: project.f
verilog/ppuRegMapPkg.sv
verilog/ppuFieldsPkg.sv
verilog/regBusIf.sv
verilog/cpuBusDecoder.sv
verilog/ctrlRegs.sv
verilog/scrollAddrRegs.sv
verilog/clipper.sv
verilog/ppuRegs.sv
dv/ppuRegs_checker.sv
dv/ppuRegs_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module ppuRegs_tb -Mdir obj_dir -o ppuRegsSim
	./obj_dir/ppuRegsSim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "simulation stopped without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/ppuRegs_input.txt
# name operation register data expected, one test per line
# register in decimal, data and expected in hex; a reg 7 write shows {strobe,we,addr,wdata}
ctrlOnes          write  0 ff ff
ctrlZero          write  0 00 00
maskShowAll       write  1 1e 1e
pixLeftShown      pixel  0 03 3
maskClipAll       write  1 18 18
pixLeftClipped    pixel  0 07 0
pixFirstFull      pixel  0 08 3
maskClipObj       write  1 1a 1a
pixLeftBgOnly     pixel  0 00 2
scrollFirst       write  5 12 0012
scrollSecond      write  5 34 3412
scrollThird       write  5 56 3456
statusMid         read   2 00 00
scrollAfterStatus write  5 78 3478
scrollFill        write  5 9a 9a78
addrHigh          write  6 e1 001a
addrLow           write  6 00 001a
dataWr0           write  7 55 3210055
dataRd            read   7 a5 a5
ctrlInc32         write  0 04 04
dataWr32          write  7 77 3210277
dataWr32b         write  7 88 3212288
addrWrapHi        write  6 3f 041a
addrWrapLo        write  6 e0 041a
dataWrWrap        write  7 99 33fe099
dataWrWrapped     write  7 aa 30000aa
oamIgnored        write  3 ab 041a
rdCtrl            read   0 00 00
rdMask            read   1 00 00
rdOam             read   3 00 00
rdScroll          read   5 00 00
rdAddr            read   6 00 00
ctrlNmiOn         write  0 80 80
vblSet            vblank 0 01 1
statusVbl         read   2 00 80
vblIdle           vblank 0 00 0
statusClear       read   2 00 00
